/* key_extract_pkg.sv */
// shared PHV/key/table layouts; VLAN must sit in metadata bits 140:129, table depth 2 to 256
package key_extract_pkg;

    // container widths and count per class
    localparam int W_6B   = 48;
    localparam int W_4B   = 32;
    localparam int W_2B   = 16;
    localparam int N_CONT = 8;
    localparam int CIDX_W = $clog2(N_CONT);

    localparam int META_W = 256;
    localparam int PHV_W  = N_CONT * (W_6B + W_4B + W_2B) + META_W;
    localparam int KEY_W  = 2 * (W_6B + W_4B + W_2B) + 1;

    // VLAN position inside the PHV, tenant index starts at VLAN bit 4
    localparam int VLAN_LSB   = 129;
    localparam int TENANT_LSB = 4;

    typedef logic [11:0] vlan_t;

    // index 7 of each class sits at the top
    typedef struct packed {
        logic [N_CONT-1:0][W_6B-1:0] c6;
        logic [N_CONT-1:0][W_4B-1:0] c4;
        logic [N_CONT-1:0][W_2B-1:0] c2;
        logic [META_W-1:0]           meta;
    } phv_t;

    typedef struct packed {
        logic [W_6B-1:0] f6_a;
        logic [W_6B-1:0] f6_b;
        logic [W_4B-1:0] f4_a;
        logic [W_4B-1:0] f4_b;
        logic [W_2B-1:0] f2_a;
        logic [W_2B-1:0] f2_b;
        logic            pred;
    } key_t;

    // set bit clears the key bit
    typedef logic [KEY_W-1:0] mask_t;

    typedef enum logic [1:0] {
        CMP_GT   = 2'd0,
        CMP_GE   = 2'd1,
        CMP_EQ   = 2'd2,
        CMP_TRUE = 2'd3
    } cmp_code_e;

    typedef enum logic [1:0] {
        CLS_2B   = 2'd0,
        CLS_4B   = 2'd1,
        CLS_6B   = 2'd2,
        CLS_NONE = 2'd3
    } cont_class_e;

    typedef enum logic {
        TBL_OFF  = 1'b0,
        TBL_MASK = 1'b1
    } tbl_sel_e;

    // non-immediate operand: bits 4:3 class, bits 2:0 index
    typedef struct packed {
        cmp_code_e  code;
        logic       op1_imm;
        logic [7:0] op1;
        logic       op2_imm;
        logic [7:0] op2;
    } cmp_desc_t;

    typedef struct packed {
        logic [CIDX_W-1:0] i6_a;
        logic [CIDX_W-1:0] i6_b;
        logic [CIDX_W-1:0] i4_a;
        logic [CIDX_W-1:0] i4_b;
        logic [CIDX_W-1:0] i2_a;
        logic [CIDX_W-1:0] i2_b;
        cmp_desc_t         cmp;
    } off_entry_t;

endpackage

/* key_table_ram.sv */
// read data appears one cycle after rd_en and holds otherwise; same-address write and read returns old entry
`timescale 1ns/1ps

module key_table_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* table_write_ctrl.sv */
// one entry per four-phase req/ack transaction; master must hold sel/index/data until ack rises
`timescale 1ns/1ps

module table_write_ctrl #(
    parameter int DEPTH = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_req,
    input  key_extract_pkg::tbl_sel_e   cfg_sel,
    input  logic [$clog2(DEPTH)-1:0]    cfg_index,
    input  key_extract_pkg::mask_t      cfg_data,
    output logic                        cfg_ack,
    output logic                        off_wr_en,
    output logic                        mask_wr_en,
    output logic [$clog2(DEPTH)-1:0]    wr_addr,
    output key_extract_pkg::off_entry_t off_wr_data,
    output key_extract_pkg::mask_t      mask_wr_data
);

    import key_extract_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_RELEASE
    } state_e;

    state_e   state;
    tbl_sel_e sel_q;
    mask_t    data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            sel_q <= TBL_OFF;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg_req) begin
                        sel_q <= cfg_sel;
                        state <= ST_WRITE;
                    end
                end
                // single write cycle
                ST_WRITE: state <= ST_RELEASE;
                ST_RELEASE: begin
                    if (!cfg_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cfg_req) begin
            wr_addr <= cfg_index;
            data_q  <= cfg_data;
        end
    end

    assign off_wr_en    = (state == ST_WRITE) && (sel_q == TBL_OFF);
    assign mask_wr_en   = (state == ST_WRITE) && (sel_q == TBL_MASK);
    // offset entry lives in the low bits
    assign off_wr_data  = off_entry_t'(data_q[$bits(off_entry_t)-1:0]);
    assign mask_wr_data = data_q;
    assign cfg_ack      = (state != ST_IDLE);

endmodule

/* lookup_ctrl.sv */
// one PHV in flight; result held and ready_out low until ready_in is seen high after key build
`timescale 1ns/1ps

module lookup_ctrl #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  key_extract_pkg::phv_t    phv_in,
    input  logic                     phv_valid_in,
    input  logic                     ready_in,
    output logic                     ready_out,
    output key_extract_pkg::phv_t    phv_out,
    output logic                     phv_valid_out,
    output logic                     key_valid_out,
    output logic                     tbl_rd_en,
    output logic [$clog2(DEPTH)-1:0] tbl_rd_addr,
    output logic                     operand_load,
    output logic                     key_load
);

    import key_extract_pkg::*;

    localparam int AW = $clog2(DEPTH);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_OPERAND,
        ST_BUILD,
        ST_HOLD
    } state_e;

    state_e state;
    phv_t   phv_q;
    vlan_t  vlan;
    logic   accept;
    logic   out_valid;

    assign accept = (state == ST_IDLE) && phv_valid_in;

    always_ff @(posedge clk) begin
        if (accept) begin
            phv_q <= phv_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP:  state <= ST_OPERAND;
                ST_OPERAND: state <= ST_BUILD;
                // key is registered on this edge, emit if downstream ready
                ST_BUILD, ST_HOLD: begin
                    if (ready_in) begin
                        out_valid <= 1'b1;
                        state     <= ST_IDLE;
                    end else begin
                        state <= ST_HOLD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // tenant index from the latched VLAN
    assign vlan          = phv_q[VLAN_LSB +: $bits(vlan_t)];
    assign tbl_rd_addr   = vlan[TENANT_LSB +: AW];
    assign tbl_rd_en     = (state == ST_LOOKUP);
    assign operand_load  = (state == ST_OPERAND);
    assign key_load      = (state == ST_BUILD);
    assign ready_out     = (state == ST_IDLE);
    assign phv_out       = phv_q;
    assign phv_valid_out = out_valid;
    assign key_valid_out = out_valid;

endmodule

/* predicate_unit.sv */
// operands are the low byte of a container or an 8-bit immediate; class "none" reads as zero
`timescale 1ns/1ps

module predicate_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  key_extract_pkg::phv_t      phv,
    input  key_extract_pkg::cmp_desc_t cmp_desc,
    input  logic                       operand_load,
    output logic                       predicate
);

    import key_extract_pkg::*;

    logic [7:0] op1_q;
    logic [7:0] op2_q;
    cmp_code_e  code_q;

    // immediate or low byte of the addressed container
    function automatic logic [7:0] fetch_operand(input logic       is_imm,
                                                 input logic [7:0] field,
                                                 input phv_t       p);
        cont_class_e       cls;
        logic [CIDX_W-1:0] idx;
        logic [7:0]        val;
        cls = cont_class_e'(field[4:3]);
        idx = field[CIDX_W-1:0];
        if (is_imm) begin
            val = field;
        end else begin
            case (cls)
                CLS_6B:  val = p.c6[idx][7:0];
                CLS_4B:  val = p.c4[idx][7:0];
                CLS_2B:  val = p.c2[idx][7:0];
                default: val = 8'd0;
            endcase
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_q  <= 8'd0;
            op2_q  <= 8'd0;
            code_q <= CMP_TRUE;
        end else if (operand_load) begin
            op1_q  <= fetch_operand(cmp_desc.op1_imm, cmp_desc.op1, phv);
            op2_q  <= fetch_operand(cmp_desc.op2_imm, cmp_desc.op2, phv);
            code_q <= cmp_desc.code;
        end
    end

    always_comb begin
        case (code_q)
            CMP_GT:  predicate = (op1_q > op2_q);
            CMP_GE:  predicate = (op1_q >= op2_q);
            CMP_EQ:  predicate = (op1_q == op2_q);
            default: predicate = 1'b1;
        endcase
    end

endmodule

/* key_assembler.sv */
// offset entry, mask and PHV must be stable on key_load; outputs hold until the next key_load
`timescale 1ns/1ps

module key_assembler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  key_extract_pkg::phv_t       phv,
    input  key_extract_pkg::off_entry_t off_entry,
    input  key_extract_pkg::mask_t      mask,
    input  logic                        predicate,
    input  logic                        key_load,
    output key_extract_pkg::key_t       key_out_masked,
    output key_extract_pkg::mask_t      key_mask_out
);

    import key_extract_pkg::*;

    key_t  key_q;
    mask_t mask_q;
    key_t  key_next;

    // six selected containers in key-field order
    always_comb begin
        key_next.f6_a = phv.c6[off_entry.i6_a];
        key_next.f6_b = phv.c6[off_entry.i6_b];
        key_next.f4_a = phv.c4[off_entry.i4_a];
        key_next.f4_b = phv.c4[off_entry.i4_b];
        key_next.f2_a = phv.c2[off_entry.i2_a];
        key_next.f2_b = phv.c2[off_entry.i2_b];
        key_next.pred = predicate;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q  <= '0;
            mask_q <= '0;
        end else if (key_load) begin
            key_q  <= key_next;
            mask_q <= mask;
        end
    end

    assign key_out_masked = key_t'(key_q & ~mask_q);
    assign key_mask_out   = mask_q;

endmodule

/* key_extract_top.sv */
// 3-cycle latency with ready_in high; TABLE_DEPTH a power of two from 2 to 256
`timescale 1ns/1ps

module key_extract_top #(
    parameter int TABLE_DEPTH = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  key_extract_pkg::phv_t          phv_in,
    input  logic                           phv_valid_in,
    output logic                           ready_out,
    output key_extract_pkg::phv_t          phv_out,
    output logic                           phv_valid_out,
    output key_extract_pkg::key_t          key_out_masked,
    output logic                           key_valid_out,
    output key_extract_pkg::mask_t         key_mask_out,
    input  logic                           ready_in,
    input  logic                           cfg_req,
    input  key_extract_pkg::tbl_sel_e      cfg_sel,
    input  logic [$clog2(TABLE_DEPTH)-1:0] cfg_index,
    input  key_extract_pkg::mask_t         cfg_data,
    output logic                           cfg_ack
);

    import key_extract_pkg::*;

    localparam int AW = $clog2(TABLE_DEPTH);

    logic          off_wr_en;
    logic          mask_wr_en;
    logic [AW-1:0] wr_addr;
    off_entry_t    off_wr_data;
    mask_t         mask_wr_data;
    logic          tbl_rd_en;
    logic [AW-1:0] tbl_rd_addr;
    off_entry_t    off_entry;
    mask_t         mask_entry;
    logic          operand_load;
    logic          key_load;
    logic          predicate;

    table_write_ctrl #(
        .DEPTH(TABLE_DEPTH)
    ) i_table_write_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_req     (cfg_req),
        .cfg_sel     (cfg_sel),
        .cfg_index   (cfg_index),
        .cfg_data    (cfg_data),
        .cfg_ack     (cfg_ack),
        .off_wr_en   (off_wr_en),
        .mask_wr_en  (mask_wr_en),
        .wr_addr     (wr_addr),
        .off_wr_data (off_wr_data),
        .mask_wr_data(mask_wr_data)
    );

    key_table_ram #(
        .payload_t(off_entry_t),
        .DEPTH    (TABLE_DEPTH)
    ) i_off_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (off_wr_en),
        .wr_addr(wr_addr),
        .wr_data(off_wr_data),
        .rd_en  (tbl_rd_en),
        .rd_addr(tbl_rd_addr),
        .rd_data(off_entry)
    );

    key_table_ram #(
        .payload_t(mask_t),
        .DEPTH    (TABLE_DEPTH)
    ) i_mask_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (mask_wr_en),
        .wr_addr(wr_addr),
        .wr_data(mask_wr_data),
        .rd_en  (tbl_rd_en),
        .rd_addr(tbl_rd_addr),
        .rd_data(mask_entry)
    );

    lookup_ctrl #(
        .DEPTH(TABLE_DEPTH)
    ) i_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .ready_in     (ready_in),
        .ready_out    (ready_out),
        .phv_out      (phv_out),
        .phv_valid_out(phv_valid_out),
        .key_valid_out(key_valid_out),
        .tbl_rd_en    (tbl_rd_en),
        .tbl_rd_addr  (tbl_rd_addr),
        .operand_load (operand_load),
        .key_load     (key_load)
    );

    predicate_unit i_predicate_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .phv         (phv_out),
        .cmp_desc    (off_entry.cmp),
        .operand_load(operand_load),
        .predicate   (predicate)
    );

    key_assembler i_key_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv           (phv_out),
        .off_entry     (off_entry),
        .mask          (mask_entry),
        .predicate     (predicate),
        .key_load      (key_load),
        .key_out_masked(key_out_masked),
        .key_mask_out  (key_mask_out)
    );

endmodule

/* tb_key_extract.sv */
// drives key_extract_top with TABLE_DEPTH 32; every table index is written before a lookup reads it
`timescale 1ns/1ps

module tb_key_extract;

    import key_extract_pkg::*;

    localparam int DEPTH = 32;
    localparam int AW    = $clog2(DEPTH);

    logic             clk = 1'b0;
    logic             rst_n;
    phv_t             phv_in;
    logic             phv_valid_in;
    logic             ready_out;
    phv_t             phv_out;
    logic             phv_valid_out;
    key_t             key_out_masked;
    logic             key_valid_out;
    mask_t            key_mask_out;
    logic             ready_in;
    logic             cfg_req;
    tbl_sel_e         cfg_sel;
    logic [AW-1:0]    cfg_index;
    mask_t            cfg_data;
    logic             cfg_ack;

    logic [31:0]      lfsr = 32'h89d9;
    off_entry_t       off_shadow [DEPTH];
    mask_t            mask_shadow [DEPTH];

    key_extract_top #(
        .TABLE_DEPTH(DEPTH)
    ) i_key_extract_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .ready_out     (ready_out),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out_masked(key_out_masked),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out),
        .ready_in      (ready_in),
        .cfg_req       (cfg_req),
        .cfg_sel       (cfg_sel),
        .cfg_index     (cfg_index),
        .cfg_data      (cfg_data),
        .cfg_ack       (cfg_ack)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [PHV_W-1:0] exp,
                               input logic [PHV_W-1:0] got);
        assert (got === exp)
            else abort_run($sformatf("[FAIL] %s expected %0h got %0h", name, exp, got));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic next_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic phv_t rand_phv(input logic [AW-1:0] idx);
        logic [PHV_W-1:0] v;
        for (int i = 0; i < PHV_W; i++) begin
            v[i] = next_bit();
        end
        v[VLAN_LSB + TENANT_LSB +: AW] = idx;
        return phv_t'(v);
    endfunction

    function automatic mask_t rand_mask();
        mask_t m;
        for (int i = 0; i < KEY_W; i++) begin
            m[i] = next_bit();
        end
        return m;
    endfunction

    // operand is the immediate or the low byte of the named container
    function automatic logic [7:0] model_operand(input logic imm, input logic [7:0] f,
                                                 input phv_t p);
        if (imm) begin
            return f;
        end
        case (f[4:3])
            CLS_2B:  return p.c2[f[2:0]][7:0];
            CLS_4B:  return p.c4[f[2:0]][7:0];
            CLS_6B:  return p.c6[f[2:0]][7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic model_pred(input cmp_desc_t d, input phv_t p);
        logic [7:0] a;
        logic [7:0] b;
        a = model_operand(d.op1_imm, d.op1, p);
        b = model_operand(d.op2_imm, d.op2, p);
        case (d.code)
            CMP_GT:  return a > b;
            CMP_GE:  return a >= b;
            CMP_EQ:  return a == b;
            default: return 1'b1;
        endcase
    endfunction

    task automatic write_entry(input tbl_sel_e sel, input logic [AW-1:0] idx, input mask_t data);
        int cnt;
        cfg_sel   = sel;
        cfg_index = idx;
        cfg_data  = data;
        @(posedge clk);
        #1;
        cfg_req = 1'b1;
        cnt = 0;
        while (!cfg_ack) begin
            if (cnt == 10) abort_run("cfg_ack never rose after cfg_req");
            @(posedge clk);
            #1;
            cnt++;
        end
        cfg_req = 1'b0;
        cnt = 0;
        while (cfg_ack) begin
            if (cnt == 10) abort_run("cfg_ack never fell after cfg_req dropped");
            @(posedge clk);
            #1;
            cnt++;
        end
        if (sel == TBL_OFF) begin
            off_shadow[idx] = off_entry_t'(data[$bits(off_entry_t)-1:0]);
        end else begin
            mask_shadow[idx] = data;
        end
    endtask

    // stall is the number of extra cycles ready_in stays low
    task automatic run_packet(input phv_t p, input int stall);
        logic [PHV_W-1:0] pv;
        logic [AW-1:0]    idx;
        off_entry_t       e;
        logic [KEY_W-1:0] exp_key;
        key_t             held_key;
        mask_t            held_mask;
        int               cnt;
        pv  = p;
        idx = pv[VLAN_LSB + TENANT_LSB +: AW];
        e   = off_shadow[idx];
        exp_key = {p.c6[e.i6_a], p.c6[e.i6_b], p.c4[e.i4_a], p.c4[e.i4_b],
                   p.c2[e.i2_a], p.c2[e.i2_b], model_pred(e.cmp, p)};
        exp_key = exp_key & ~mask_shadow[idx];
        cnt = 0;
        while (!ready_out) begin
            if (cnt == 20) abort_run("ready_out stayed low before a new PHV");
            @(posedge clk);
            #1;
            cnt++;
        end
        ready_in     = (stall == 0);
        phv_in       = p;
        phv_valid_in = 1'b1;
        @(posedge clk);
        #1;
        phv_valid_in = 1'b0;
        cnt = 0;
        while (!phv_valid_out) begin
            if (cnt > stall + 16) abort_run("no valid output after the PHV was accepted");
            check_value("ready_out", PHV_W'(0), PHV_W'(ready_out));
            if (cnt == 3) begin
                held_key  = key_out_masked;
                held_mask = key_mask_out;
            end
            if (stall > 0 && cnt == stall + 2) ready_in = 1'b1;
            @(posedge clk);
            #1;
            cnt++;
        end
        assert (cnt == 3 + stall)
            else abort_run($sformatf("valid output came %0d cycles after acceptance, not %0d",
                                     cnt, 3 + stall));
        check_value("key_out_masked", PHV_W'(exp_key), PHV_W'(key_out_masked));
        check_value("key_mask_out", PHV_W'(mask_shadow[idx]), PHV_W'(key_mask_out));
        check_value("phv_out", pv, PHV_W'(phv_out));
        if (stall > 0) begin
            check_value("held key_out_masked", PHV_W'(held_key), PHV_W'(key_out_masked));
            check_value("held key_mask_out", PHV_W'(held_mask), PHV_W'(key_mask_out));
        end
        @(posedge clk);
        #1;
        check_value("phv_valid_out", PHV_W'(0), PHV_W'(phv_valid_out));
        check_value("phv_out", pv, PHV_W'(phv_out));
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) phv_valid_out == key_valid_out)
        else abort_run($sformatf("[FAIL] key_valid_out expected %h got %h",
                                 phv_valid_out, key_valid_out));
    assert property (@(posedge clk) disable iff (!rst_n) phv_valid_out |-> $past(ready_in))
        else abort_run("valid output appeared while ready_in was low");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(cfg_ack) |-> $past(cfg_req))
        else abort_run("cfg_ack rose without cfg_req");
    assert property (@(posedge clk) disable iff (!rst_n) $fell(cfg_ack) |-> !$past(cfg_req))
        else abort_run("cfg_ack fell while cfg_req was still high");

    initial begin
        off_entry_t    e;
        phv_t          p;
        logic [AW-1:0] idx;
        logic [AW-1:0] idx_b;
        int            stall;
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        ready_in     = 1'b1;
        cfg_req      = 1'b0;
        cfg_sel      = TBL_OFF;
        cfg_index    = '0;
        cfg_data     = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("ready_out", PHV_W'(1), PHV_W'(ready_out));
        check_value("phv_valid_out", PHV_W'(0), PHV_W'(phv_valid_out));
        check_value("key_valid_out", PHV_W'(0), PHV_W'(key_valid_out));
        check_value("cfg_ack", PHV_W'(0), PHV_W'(cfg_ack));

        // all compare codes, both operand sources
        for (int i = 0; i < 16; i++) begin
            idx = AW'(rand_bits(AW));
            e   = off_entry_t'({18'(rand_bits(18)), 20'd0});
            e.cmp.code    = cmp_code_e'(i[1:0]);
            e.cmp.op1_imm = i[2];
            e.cmp.op1     = 8'(rand_bits(8));
            e.cmp.op2_imm = i[3];
            e.cmp.op2     = 8'(rand_bits(8));
            if (i == 14) e.cmp.op2 = e.cmp.op1;
            write_entry(TBL_OFF, idx, mask_t'(e));
            write_entry(TBL_MASK, idx, rand_mask());
            stall = i[0] ? 1 + int'(rand_bits(3)) : 0;
            run_packet(rand_phv(idx), stall);
        end

        // two tenants, same PHV body
        idx   = AW'(rand_bits(AW));
        idx_b = idx ^ AW'(5'h15);
        write_entry(TBL_OFF, idx, rand_mask());
        write_entry(TBL_MASK, idx, rand_mask());
        write_entry(TBL_OFF, idx_b, rand_mask());
        write_entry(TBL_MASK, idx_b, rand_mask());
        p = rand_phv(idx);
        run_packet(p, 0);
        p[VLAN_LSB + TENANT_LSB +: AW] = idx_b;
        run_packet(p, 0);

        $display("Regression passed");
        $finish;
    end

endmodule

/* src.f */
key_extract_pkg.sv
key_table_ram.sv
table_write_ctrl.sv
lookup_ctrl.sv
predicate_unit.sv
key_assembler.sv
key_extract_top.sv
tb_key_extract.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_key_extract -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/Vtb_key_extract
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
fi
exit $status
